//--- hw/oc_pkg.sv
`default_nettype none

package oc_pkg;

    localparam int num_collectors = 4;
    localparam int num_regs       = 32;
    localparam int num_banks      = 2;
    localparam int num_rows       = num_regs / num_banks;
    localparam int num_lanes      = 8;
    localparam int lane_width     = 32;

    typedef logic [num_lanes*lane_width-1:0]    lane_vec_t;  // one operand, all lanes
    typedef logic [$clog2(num_regs)-1:0]        reg_id_t;
    typedef logic [$clog2(num_rows)-1:0]        row_t;
    typedef logic [$clog2(num_banks)-1:0]       bank_t;
    typedef logic [1:0]                         scb_id_t;
    typedef logic [num_lanes-1:0]               active_mask_t;
    typedef logic [3:0]                         alu_op_t;
    typedef logic [15:0]                        imme_t;
    typedef logic [31:0]                        instr_t;
    typedef logic [num_collectors-1:0]          coll_sel_t;  // one-hot or bit per slot
    typedef logic [$clog2(num_collectors)-1:0]  coll_idx_t;

    typedef struct packed {
        instr_t       instr;
        logic         reg_write;
        imme_t        imme;
        logic         imme_valid;
        alu_op_t      alu_op;
        logic         mem_write;
        logic         mem_read;
        logic         shared_global;
        logic         beq;
        logic         blt;
        scb_id_t      scb_id;
        active_mask_t active_mask;
        reg_id_t      dst;
    } oc_ctrl_t;

    typedef struct packed {
        oc_ctrl_t ctrl;
        reg_id_t  src0;
        reg_id_t  src1;
    } oc_issue_t;

    typedef struct packed {
        logic    req0;
        logic    req1;
        reg_id_t reg0;
        reg_id_t reg1;
    } rd_req_t;

    typedef struct packed {
        logic      ack0;
        logic      ack1;
        lane_vec_t data0;
        lane_vec_t data1;
    } rd_rsp_t;

    // even registers in bank 0, odd in bank 1
    function automatic bank_t bank_of(reg_id_t r);
        return r[0];
    endfunction

    function automatic row_t row_of(reg_id_t r);
        return r[$bits(reg_id_t)-1:1];
    endfunction

endpackage

`default_nettype wire

//--- hw/banked_regfile.sv
`timescale 1ns/1ps
`default_nettype none

module banked_regfile
    import oc_pkg::*;
(
    input  logic      clk,
    input  logic      reset,
    input  logic      wr_en,
    input  reg_id_t   wr_reg,
    input  lane_vec_t wr_data,
    input  rd_req_t   rd_req [num_collectors],
    output rd_rsp_t   rd_rsp [num_collectors]
);

    lane_vec_t bank_mem [num_banks][num_rows];
    lane_vec_t bank_rd_q [num_banks];
    row_t      bank_row [num_banks];
    logic [num_banks-1:0] bank_taken;
    coll_sel_t gnt0;
    coll_sel_t gnt1;
    coll_sel_t ack0_q;
    coll_sel_t ack1_q;
    bank_t     sel0_q [num_collectors];
    bank_t     sel1_q [num_collectors];
    logic [num_banks-1:0][2*num_collectors-1:0] bank_ack;

    // one port per bank, lowest collector wins, src0 before src1
    always_comb
    begin
        bank_taken = '0;
        gnt0 = '0;
        gnt1 = '0;
        for (int b = 0; b < num_banks; b++)
        begin
            bank_row[b] = '0;
        end
        for (int c = 0; c < num_collectors; c++)
        begin
            if (rd_req[c].req0 && !bank_taken[bank_of(rd_req[c].reg0)])
            begin
                gnt0[c] = 1'b1;
                bank_taken[bank_of(rd_req[c].reg0)] = 1'b1;
                bank_row[bank_of(rd_req[c].reg0)] = row_of(rd_req[c].reg0);
            end
            if (rd_req[c].req1 && !bank_taken[bank_of(rd_req[c].reg1)])
            begin
                gnt1[c] = 1'b1;
                bank_taken[bank_of(rd_req[c].reg1)] = 1'b1;
                bank_row[bank_of(rd_req[c].reg1)] = row_of(rd_req[c].reg1);
            end
        end
    end

    always_ff @(posedge clk)
    begin
        if (wr_en)
        begin
            bank_mem[bank_of(wr_reg)][row_of(wr_reg)] <= wr_data;
        end
        for (int b = 0; b < num_banks; b++)
        begin
            if (bank_taken[b])
            begin
                bank_rd_q[b] <= bank_mem[b][bank_row[b]];  // old value on same-cycle write
            end
        end
        for (int c = 0; c < num_collectors; c++)
        begin
            sel0_q[c] <= bank_of(rd_req[c].reg0);
            sel1_q[c] <= bank_of(rd_req[c].reg1);
        end
    end

    always_ff @(posedge clk)
    begin
        if (reset)
        begin
            ack0_q <= '0;
            ack1_q <= '0;
        end
        else
        begin
            ack0_q <= gnt0;
            ack1_q <= gnt1;
        end
    end

    always_comb
    begin
        bank_ack = '0;
        for (int c = 0; c < num_collectors; c++)
        begin
            rd_rsp[c].ack0  = ack0_q[c];
            rd_rsp[c].ack1  = ack1_q[c];
            rd_rsp[c].data0 = bank_rd_q[sel0_q[c]];
            rd_rsp[c].data1 = bank_rd_q[sel1_q[c]];
            bank_ack[sel0_q[c]][2*c]   = ack0_q[c];
            bank_ack[sel1_q[c]][2*c+1] = ack1_q[c];
        end
    end

    for (genvar b = 0; b < num_banks; b++)
    begin : g_bank_chk
        a_one_ack_per_bank: assert property (
            @(posedge clk) disable iff (reset) $onehot0(bank_ack[b]));
    end

endmodule

`default_nettype wire

//--- hw/collector_unit.sv
`timescale 1ns/1ps
`default_nettype none

module collector_unit
    import oc_pkg::*;
(
    input  logic      clk,
    input  logic      reset,
    input  logic      load,
    input  oc_issue_t issue,
    input  logic      release_slot,
    output rd_req_t   rd_req,
    input  rd_rsp_t   rd_rsp,
    output logic      free,
    output logic      ready,
    output oc_ctrl_t  ctrl,
    output lane_vec_t op0,
    output lane_vec_t op1
);

    typedef enum logic [1:0] {st_idle, st_collecting, st_ready} cu_state_t;

    cu_state_t state;
    logic      have0;
    logic      have1;
    logic      take0;
    logic      take1;
    oc_ctrl_t  ctrl_q;
    reg_id_t   src0_q;
    reg_id_t   src1_q;
    lane_vec_t op0_q;
    lane_vec_t op1_q;

    assign take0 = (state == st_collecting) && rd_rsp.ack0;
    assign take1 = (state == st_collecting) && rd_rsp.ack1;

    always_ff @(posedge clk)
    begin
        if (reset)
        begin
            state <= st_idle;
            have0 <= 1'b0;
            have1 <= 1'b0;
        end
        else
        begin
            case (state)
                st_idle:
                begin
                    if (load)
                    begin
                        state <= st_collecting;
                        have0 <= 1'b0;
                        have1 <= issue.ctrl.imme_valid;  // immediates skip src1
                    end
                end
                st_collecting:
                begin
                    if (take0)
                    begin
                        have0 <= 1'b1;
                    end
                    if (take1)
                    begin
                        have1 <= 1'b1;
                    end
                    if ((have0 || take0) && (have1 || take1))
                    begin
                        state <= st_ready;
                    end
                end
                st_ready:
                begin
                    if (release_slot)
                    begin
                        state <= st_idle;
                    end
                end
                default: state <= st_idle;
            endcase
        end
    end

    always_ff @(posedge clk)
    begin
        if (load)
        begin
            ctrl_q <= issue.ctrl;
            src0_q <= issue.src0;
            src1_q <= issue.src1;
            op1_q  <= '0;  // stays zero for immediates
        end
        if (take0)
        begin
            op0_q <= rd_rsp.data0;
        end
        if (take1)
        begin
            op1_q <= rd_rsp.data1;
        end
    end

    // hold off while an ack is in flight
    assign rd_req.req0 = (state == st_collecting) && !have0 && !rd_rsp.ack0;
    assign rd_req.req1 = (state == st_collecting) && !have1 && !rd_rsp.ack1;
    assign rd_req.reg0 = src0_q;
    assign rd_req.reg1 = src1_q;

    assign free  = (state == st_idle);
    assign ready = (state == st_ready);
    assign ctrl  = ctrl_q;
    assign op0   = op0_q;
    assign op1   = op1_q;

    a_load_when_idle: assert property (
        @(posedge clk) disable iff (reset) load |-> state == st_idle);
    a_release_when_ready: assert property (
        @(posedge clk) disable iff (reset) release_slot |-> state == st_ready);

endmodule

`default_nettype wire

//--- hw/dispatch_arbiter.sv
`timescale 1ns/1ps
`default_nettype none

module dispatch_arbiter
    import oc_pkg::*;
(
    input  logic      clk,
    input  logic      reset,
    input  coll_sel_t ready,
    input  logic      ex_stall,
    output coll_sel_t grant
);

    coll_idx_t last_q;
    coll_idx_t grant_idx;
    coll_idx_t cand;

    // search starts one past the last winner
    always_comb
    begin
        grant = '0;
        grant_idx = last_q;
        cand = last_q;
        for (int i = 1; i <= num_collectors; i++)
        begin
            cand = last_q + coll_idx_t'(i);  // wraps at the index width
            if (!ex_stall && grant == '0 && ready[cand])
            begin
                grant[cand] = 1'b1;
                grant_idx = cand;
            end
        end
    end

    always_ff @(posedge clk)
    begin
        if (reset)
        begin
            last_q <= coll_idx_t'(num_collectors - 1);  // slot 0 goes first
        end
        else if (|grant)
        begin
            last_q <= grant_idx;
        end
    end

    a_grant_onehot0: assert property (
        @(posedge clk) disable iff (reset) $onehot0(grant));

endmodule

`default_nettype wire

//--- hw/dispatch_mux.sv
`timescale 1ns/1ps
`default_nettype none

module dispatch_mux
    import oc_pkg::*;
(
    input  coll_sel_t grant,
    input  oc_ctrl_t  ctrl_in [num_collectors],
    input  lane_vec_t op0_in [num_collectors],
    input  lane_vec_t op1_in [num_collectors],
    output logic      valid_ex,
    output oc_ctrl_t  ex_ctrl,
    output lane_vec_t oc_0_data,
    output lane_vec_t oc_1_data
);

    always_comb
    begin
        valid_ex = |grant;

        case (grant)
            4'b0001:
            begin
                ex_ctrl   = ctrl_in[0];
                oc_0_data = op0_in[0];
                oc_1_data = op1_in[0];
            end
            4'b0010:
            begin
                ex_ctrl   = ctrl_in[1];
                oc_0_data = op0_in[1];
                oc_1_data = op1_in[1];
            end
            4'b0100:
            begin
                ex_ctrl   = ctrl_in[2];
                oc_0_data = op0_in[2];
                oc_1_data = op1_in[2];
            end
            default:  // slot 3, or don't-care with no grant
            begin
                ex_ctrl   = ctrl_in[3];
                oc_0_data = op0_in[3];
                oc_1_data = op1_in[3];
            end
        endcase
    end

endmodule

`default_nettype wire

//--- hw/operand_collect_stage.sv
`timescale 1ns/1ps
`default_nettype none

module operand_collect_stage
    import oc_pkg::*;
(
    input  logic      clk,
    input  logic      reset,
    input  logic      issue_valid,
    input  oc_issue_t issue,
    output logic      issue_ready,
    input  logic      rf_wr_en,
    input  reg_id_t   rf_wr_reg,
    input  lane_vec_t rf_wr_data,
    input  logic      ex_stall,
    output logic      valid_ex,
    output oc_ctrl_t  ex_ctrl,
    output lane_vec_t oc_0_data,
    output lane_vec_t oc_1_data
);

    coll_sel_t free;
    coll_sel_t ready;
    coll_sel_t grant;
    coll_sel_t load;
    rd_req_t   rd_req [num_collectors];
    rd_rsp_t   rd_rsp [num_collectors];
    oc_ctrl_t  coll_ctrl [num_collectors];
    lane_vec_t coll_op0 [num_collectors];
    lane_vec_t coll_op1 [num_collectors];

    assign issue_ready = |free;

    // lowest free slot takes the issue
    assign load = issue_valid ? (free & (~free + coll_sel_t'(1))) : '0;

    banked_regfile u_regfile (
        .clk     (clk),
        .reset   (reset),
        .wr_en   (rf_wr_en),
        .wr_reg  (rf_wr_reg),
        .wr_data (rf_wr_data),
        .rd_req  (rd_req),
        .rd_rsp  (rd_rsp)
    );

    for (genvar g = 0; g < num_collectors; g++)
    begin : g_coll
        collector_unit u_coll (
            .clk          (clk),
            .reset        (reset),
            .load         (load[g]),
            .issue        (issue),
            .release_slot (grant[g]),  // freed on dispatch
            .rd_req       (rd_req[g]),
            .rd_rsp       (rd_rsp[g]),
            .free         (free[g]),
            .ready        (ready[g]),
            .ctrl         (coll_ctrl[g]),
            .op0          (coll_op0[g]),
            .op1          (coll_op1[g])
        );
    end

    dispatch_arbiter u_arbiter (
        .clk      (clk),
        .reset    (reset),
        .ready    (ready),
        .ex_stall (ex_stall),
        .grant    (grant)
    );

    dispatch_mux u_dispatch_mux (
        .grant     (grant),
        .ctrl_in   (coll_ctrl),
        .op0_in    (coll_op0),
        .op1_in    (coll_op1),
        .valid_ex  (valid_ex),
        .ex_ctrl   (ex_ctrl),
        .oc_0_data (oc_0_data),
        .oc_1_data (oc_1_data)
    );

endmodule

`default_nettype wire

//--- verification/tb_operand_collect.sv
`timescale 1ns/1ps
`default_nettype none

module tb_operand_collect
    import oc_pkg::*;
();

    localparam int clk_period   = 40;
    localparam int reset_cycles = 10;
    localparam int n_stall      = num_collectors;
    localparam int n_random     = 200;
    localparam int n_mixed      = 100;
    localparam int cycle_budget = 30;   // worst case per instruction under random stall
    localparam int fixed_cycles = 300;  // reset, preload, stall hold, drain
    localparam int drain_limit  = num_collectors * cycle_budget;

    typedef struct packed {
        lane_vec_t op0;
        lane_vec_t op1;
    } exp_ops_t;

    logic      clk;
    logic      reset;
    logic      issue_valid;
    oc_issue_t issue;
    logic      issue_ready;
    logic      rf_wr_en;
    reg_id_t   rf_wr_reg;
    lane_vec_t rf_wr_data;
    logic      ex_stall = 1'b0;
    logic      valid_ex;
    oc_ctrl_t  ex_ctrl;
    lane_vec_t oc_0_data;
    lane_vec_t oc_1_data;

    logic [1:0] stall_mode = 2'd0;  // 0 off, 1 held, 2 random
    lane_vec_t  model_regs [num_regs];
    oc_issue_t  pending [instr_t];  // outstanding entries keyed by instr word
    string      pending_test [instr_t];
    string      cur_test = "reset";
    int         n_issued = 0;
    int         n_dispatched = 0;
    int         mismatch_errs = 0;
    int         other_errs = 0;
    int         seq = 0;

    operand_collect_stage UUT (
        .clk         (clk),
        .reset       (reset),
        .issue_valid (issue_valid),
        .issue       (issue),
        .issue_ready (issue_ready),
        .rf_wr_en    (rf_wr_en),
        .rf_wr_reg   (rf_wr_reg),
        .rf_wr_data  (rf_wr_data),
        .ex_stall    (ex_stall),
        .valid_ex    (valid_ex),
        .ex_ctrl     (ex_ctrl),
        .oc_0_data   (oc_0_data),
        .oc_1_data   (oc_1_data)
    );

    initial
    begin
        clk = 1'b0;
        forever #(clk_period / 2) clk = ~clk;
    end

    initial
    begin
        #((((n_stall + n_random + n_mixed) * cycle_budget) + fixed_cycles) * clk_period);
        $display("timeout: run went past its cycle budget, %0d of %0d dispatched",
                 n_dispatched, n_issued);
        $display("TESTS FAILED");
        $finish;
    end

    always @(posedge clk)
    begin
        case (stall_mode)
            2'd1: ex_stall <= 1'b1;
            2'd2: ex_stall <= ($urandom_range(2, 0) == 0);  // about one cycle in three
            default: ex_stall <= 1'b0;
        endcase
    end

    // expected operands straight from the model registers
    function automatic exp_ops_t ref_operands(oc_issue_t ins);
        exp_ops_t e;
        e.op0 = model_regs[ins.src0];
        e.op1 = ins.ctrl.imme_valid ? '0 : model_regs[ins.src1];
        return e;
    endfunction

    function automatic oc_issue_t make_instr(int id);
        oc_issue_t   ins;
        logic [31:0] r0;
        logic [31:0] r1;
        logic [31:0] r2;
        r0 = $urandom;
        r1 = $urandom;
        r2 = $urandom;
        ins.ctrl.instr         = {r0[31:16], id[15:0]};  // low half keeps it unique
        ins.ctrl.reg_write     = r0[0];
        ins.ctrl.imme          = r1[15:0];
        ins.ctrl.imme_valid    = (r0[3:2] == 2'b00);
        ins.ctrl.alu_op        = r0[7:4];
        ins.ctrl.mem_write     = r0[8];
        ins.ctrl.mem_read      = r0[9];
        ins.ctrl.shared_global = r0[10];
        ins.ctrl.beq           = r0[11];
        ins.ctrl.blt           = r0[12];
        ins.ctrl.scb_id        = r0[14:13];
        ins.ctrl.active_mask   = r1[23:16];
        ins.ctrl.dst           = r1[28:24];
        ins.src0               = r2[4:0];
        case (r2[9:8])
            2'd0: ins.src1 = ins.src0;                  // same register twice
            2'd1: ins.src1 = {r2[13:10], ins.src0[0]};  // same bank as src0
            default: ins.src1 = r2[18:14];
        endcase
        return ins;
    endfunction

    task automatic check_value(string test, string what, logic [255:0] exp,
                               logic [255:0] act);
        assert (exp === act)
        else
        begin
            mismatch_errs++;
            $display("MISMATCH %s %s: expected %h actual %h", test, what, exp, act);
        end
    endtask

    task automatic preload_regs();
        lane_vec_t val;
        for (int r = 0; r < num_regs; r++)
        begin
            for (int l = 0; l < num_lanes; l++)
            begin
                val[l*lane_width +: lane_width] = {r[7:0], 24'($urandom)};
            end
            model_regs[r] = val;
            rf_wr_en   <= 1'b1;
            rf_wr_reg  <= reg_id_t'(r);
            rf_wr_data <= val;
            @(posedge clk);
        end
        rf_wr_en <= 1'b0;
        @(posedge clk);
    endtask

    // returns at the rising edge that takes the issue
    task automatic send(input oc_issue_t ins);
        bit taken;
        taken = 1'b0;
        issue_valid <= 1'b1;
        issue       <= ins;
        while (!taken)
        begin
            @(negedge clk);
            taken = issue_ready;
            @(posedge clk);
        end
        pending[ins.ctrl.instr]      = ins;
        pending_test[ins.ctrl.instr] = cur_test;
        n_issued++;
    endtask

    task automatic idle_cycles(int n);
        issue_valid <= 1'b0;
        repeat (n) @(posedge clk);
    endtask

    task automatic drain();
        int waited;
        waited = 0;
        issue_valid <= 1'b0;
        while (pending.size() != 0 && waited < drain_limit)
        begin
            @(posedge clk);
            waited++;
        end
        assert (pending.size() == 0)
        else
        begin
            other_errs++;
            $display("%0d instructions still outstanding after drain in %s",
                     pending.size(), cur_test);
        end
        repeat (4) @(posedge clk);
    endtask

    always @(negedge clk)
    begin
        exp_ops_t  e;
        oc_issue_t ent;
        string     tname;
        if (!reset)
        begin
            assert (!(valid_ex && ex_stall))
            else
            begin
                other_errs++;
                $display("valid_ex went high while ex_stall was high");
            end
            if (valid_ex)
            begin
                assert (pending.exists(ex_ctrl.instr))
                else
                begin
                    other_errs++;
                    $display("instr %h dispatched but not outstanding, unknown or duplicate",
                             ex_ctrl.instr);
                end
                if (pending.exists(ex_ctrl.instr))
                begin
                    ent   = pending[ex_ctrl.instr];
                    tname = pending_test[ex_ctrl.instr];
                    e     = ref_operands(ent);
                    check_value(tname, $sformatf("instr %h ctrl", ent.ctrl.instr),
                                256'(ent.ctrl), 256'(ex_ctrl));
                    check_value(tname, $sformatf("instr %h oc_0", ent.ctrl.instr),
                                e.op0, oc_0_data);
                    check_value(tname, $sformatf("instr %h oc_1", ent.ctrl.instr),
                                e.op1, oc_1_data);
                    pending.delete(ex_ctrl.instr);
                    pending_test.delete(ex_ctrl.instr);
                    n_dispatched++;
                end
            end
        end
    end

    initial
    begin
        void'($urandom(36045));
        reset       = 1'b1;
        issue_valid = 1'b0;
        issue       = '0;
        rf_wr_en    = 1'b0;
        rf_wr_reg   = '0;
        rf_wr_data  = '0;
        repeat (reset_cycles) @(posedge clk);
        reset <= 1'b0;

        cur_test = "after_reset";
        @(negedge clk);
        check_value(cur_test, "valid_ex", 256'(1'b0), 256'(valid_ex));
        check_value(cur_test, "issue_ready", 256'(1'b1), 256'(issue_ready));
        @(posedge clk);
        preload_regs();
        @(negedge clk);
        check_value(cur_test, "valid_ex before issue", 256'(1'b0), 256'(valid_ex));
        check_value(cur_test, "issue_ready before issue", 256'(1'b1), 256'(issue_ready));
        @(posedge clk);

        cur_test = "stall_hold";
        stall_mode <= 2'd1;
        repeat (2) @(posedge clk);
        for (int i = 0; i < n_stall; i++)
        begin
            seq++;
            send(make_instr(seq));
        end
        idle_cycles(8);  // all slots full and stalled
        @(negedge clk);
        check_value(cur_test, "issue_ready when full", 256'(1'b0), 256'(issue_ready));
        @(posedge clk);
        stall_mode <= 2'd0;
        drain();

        cur_test = "random_ops";
        for (int i = 0; i < n_random; i++)
        begin
            seq++;
            send(make_instr(seq));
        end
        drain();

        cur_test = "random_stall";
        stall_mode <= 2'd2;
        for (int i = 0; i < n_mixed; i++)
        begin
            if ($urandom_range(3, 0) == 0)
            begin
                idle_cycles($urandom_range(3, 1));
            end
            seq++;
            send(make_instr(seq));
        end
        stall_mode <= 2'd0;
        drain();

        cur_test = "final";
        @(negedge clk);
        check_value(cur_test, "dispatch count", 256'(n_issued), 256'(n_dispatched));
        $display("errors: %0d mismatch, %0d other; issued %0d, dispatched %0d",
                 mismatch_errs, other_errs, n_issued, n_dispatched);
        if (mismatch_errs + other_errs == 0)
        begin
            $display("TESTS PASSED");
        end
        else
        begin
            $display("TESTS FAILED");
        end
        $finish;
    end

endmodule

`default_nettype wire

//--- project.f
hw/oc_pkg.sv
hw/banked_regfile.sv
hw/collector_unit.sv
hw/dispatch_arbiter.sv
hw/dispatch_mux.sv
hw/operand_collect_stage.sv
verification/tb_operand_collect.sv

//--- run_sim.sh
#!/usr/bin/env bash
# build the testbench with Verilator, run it, and grade the log
cd "$(dirname "$0")" || exit 1
rm -rf obj_dir build.log sim.log

verilator --binary --timing --assert -Wno-fatal \
    --top-module tb_operand_collect -f project.f -o sim_tb \
    > build.log 2>&1 \
    && ./obj_dir/sim_tb > sim.log 2>&1 \
    || { echo "build or run failed"; cat build.log sim.log 2>/dev/null; exit 1; }

cat sim.log
grep -qx "TESTS PASSED" sim.log \
    && { echo "result: pass"; exit 0; } \
    || { echo "result: fail"; exit 1; }
